/* tex_cache_config.svh */
`ifndef TEX_CACHE_CONFIG_SVH
`define TEX_CACHE_CONFIG_SVH

// colour components, one RAM bank each
`define TEX_COMPONENT_NUM       3
`define TEX_COMPONENT_WIDTH     8

// slot and pixel addressing
`define TEX_TAG_ADDR_WIDTH      4
`define TEX_PIX_ADDR_WIDTH      4

// log2 of pixels per RAM line
`define TEX_LINE_SIZE           2
`define TEX_LINE_PIX            (1 << `TEX_LINE_SIZE)

`define TEX_USER_WIDTH          4

// returned for out of range lookups, component 2 first
`define TEX_BORDER_DATA         {8'hff, 8'h80, 8'h00}

`endif

/* tex_cache_pkg.sv */
`default_nettype none

`include "tex_cache_config.svh"

package tex_cache_pkg;

	// ----------------------------------------
	// pixel data
	// ----------------------------------------
	typedef logic [`TEX_COMPONENT_WIDTH-1:0] comp_t;

	// one bank's line, written whole and read per pixel
	typedef union packed {
		logic [`TEX_LINE_PIX*`TEX_COMPONENT_WIDTH-1:0] word;
		comp_t [`TEX_LINE_PIX-1:0]                     pix;
	} line_u;

	typedef comp_t [`TEX_COMPONENT_NUM-1:0] pixel_t;
	typedef line_u [`TEX_COMPONENT_NUM-1:0] line_set_t;

	// ----------------------------------------
	// addressing and sideband
	// ----------------------------------------
	typedef logic [`TEX_TAG_ADDR_WIDTH-1:0] tag_addr_t;
	typedef logic [`TEX_PIX_ADDR_WIDTH-1:0] pix_addr_t;

	// tag, then line index inside the slot
	typedef logic [`TEX_TAG_ADDR_WIDTH+`TEX_PIX_ADDR_WIDTH-`TEX_LINE_SIZE-1:0] word_addr_t;

	typedef logic [`TEX_LINE_SIZE-1:0]  pix_sel_t;
	typedef logic [`TEX_USER_WIDTH-1:0] user_t;

endpackage

`default_nettype wire

/* tex_cache_req_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tex_cache_config.svh"

module tex_cache_req_decode (
	input  wire logic                     clk,
	input  wire logic                     reset,
	input  wire logic                     cke,

	input  wire logic                     valid,
	input  wire logic                     last,
	input  wire logic                     range_out,
	input  wire tex_cache_pkg::user_t     user,
	input  wire tex_cache_pkg::pix_addr_t pix_addr,
	input  wire tex_cache_pkg::tag_addr_t tag_addr,

	output tex_cache_pkg::word_addr_t     word_addr,

	output tex_cache_pkg::pix_sel_t       st2_sel,
	output logic                          st2_valid,
	output logic                          st2_last,
	output logic                          st2_range_out,
	output tex_cache_pkg::user_t          st2_user
);

	tex_cache_pkg::pix_sel_t st1_sel;
	logic                    st1_valid;
	logic                    st1_last;
	logic                    st1_range_out;
	tex_cache_pkg::user_t    st1_user;

	// stage 0, straight to the banks
	assign word_addr = {tag_addr, pix_addr[`TEX_PIX_ADDR_WIDTH-1:`TEX_LINE_SIZE]};

	// ----------------------------------------
	// stages 1 and 2, waiting on RAM latency
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			st1_valid <= 1'b0;
			st2_valid <= 1'b0;
		end else if (cke) begin
			st1_valid <= valid;
			st2_valid <= st1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (cke) begin
			st1_sel       <= pix_addr[`TEX_LINE_SIZE-1:0];
			st1_last      <= last;
			st1_range_out <= range_out;
			st1_user      <= user;

			st2_sel       <= st1_sel;
			st2_last      <= st1_last;
			st2_range_out <= st1_range_out;
			st2_user      <= st1_user;
		end
	end

endmodule

`default_nettype wire

/* tex_cache_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module tex_cache_ram (
	input  wire logic                      clk,
	input  wire logic                      cke,

	input  wire logic                      we,
	input  wire tex_cache_pkg::word_addr_t addr,
	input  wire tex_cache_pkg::line_u      wdata,
	output tex_cache_pkg::line_u           rdata
);

	localparam int DEPTH = 1 << $bits(tex_cache_pkg::word_addr_t);
	localparam int WIDTH = $bits(tex_cache_pkg::line_u);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [WIDTH-1:0] rd_word;

	// ----------------------------------------
	// array access, read before write
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (cke) begin
			rd_word <= mem[addr];
			if (we) begin
				mem[addr] <= wdata.word;
			end
		end
	end

	// output register, second read cycle
	always_ff @(posedge clk) begin
		if (cke) begin
			rdata.word <= rd_word;
		end
	end

endmodule

`default_nettype wire

/* tex_cache_pix_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tex_cache_config.svh"

module tex_cache_pix_select (
	input  wire logic                     clk,
	input  wire logic                     reset,
	input  wire logic                     cke,
	input  wire logic                     endian,

	input  wire tex_cache_pkg::pix_sel_t  sel,
	input  wire logic                     range_out,
	input  wire logic                     valid,
	input  wire logic                     last,
	input  wire tex_cache_pkg::user_t     user,
	input  wire tex_cache_pkg::line_set_t lines,

	output tex_cache_pkg::pixel_t         pixel,
	output logic                          out_valid,
	output logic                          out_last,
	output tex_cache_pkg::user_t          out_user
);

	tex_cache_pkg::pix_sel_t pick;
	tex_cache_pkg::pixel_t   sel_pixel;

	// big endian lines hold pixel 0 at the top
	assign pick = endian ? ~sel : sel;

	// ----------------------------------------
	// one pixel out of every bank's line
	// ----------------------------------------
	always_comb begin
		for (int i = 0; i < `TEX_COMPONENT_NUM; i++) begin
			sel_pixel[i] = lines[i].pix[pick];
		end
	end

	// stage 3
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (cke) begin
			out_valid <= valid;
		end
	end

	always_ff @(posedge clk) begin
		if (cke) begin
			// border colour wins over memory data
			pixel    <= range_out ? tex_cache_pkg::pixel_t'(`TEX_BORDER_DATA) : sel_pixel;
			out_last <= last;
			out_user <= user;
		end
	end

endmodule

`default_nettype wire

/* tex_cache_out_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tex_cache_out_buffer (
	input  wire logic                  clk,
	input  wire logic                  reset,

	input  wire tex_cache_pkg::pixel_t s_pixel,
	input  wire tex_cache_pkg::user_t  s_user,
	input  wire logic                  s_last,
	input  wire logic                  s_valid,
	output logic                       s_ready,

	output tex_cache_pkg::pixel_t      m_pixel,
	output tex_cache_pkg::user_t       m_user,
	output logic                       m_last,
	output logic                       m_valid,
	input  wire logic                  m_ready
);

	tex_cache_pkg::pixel_t skid_pixel;
	tex_cache_pkg::user_t  skid_user;
	logic                  skid_last;
	logic                  out_free;

	// output register can take a new beat this cycle
	assign out_free = !m_valid || m_ready;

	// ----------------------------------------
	// control
	// ----------------------------------------
	// skid register is full exactly while s_ready is low
	always_ff @(posedge clk) begin
		if (reset) begin
			s_ready <= 1'b1;
			m_valid <= 1'b0;
		end else if (s_ready) begin
			if (out_free) begin
				m_valid <= s_valid;
			end else if (s_valid) begin
				s_ready <= 1'b0;
			end
		end else if (m_ready) begin
			m_valid <= 1'b1;
			s_ready <= 1'b1;
		end
	end

	// ----------------------------------------
	// data path
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (s_ready) begin
			if (out_free) begin
				m_pixel <= s_pixel;
				m_user  <= s_user;
				m_last  <= s_last;
			end else begin
				skid_pixel <= s_pixel;
				skid_user  <= s_user;
				skid_last  <= s_last;
			end
		end else if (m_ready) begin
			// drain the held beat first, keeps order
			m_pixel <= skid_pixel;
			m_user  <= skid_user;
			m_last  <= skid_last;
		end
	end

endmodule

`default_nettype wire

/* tex_cache_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tex_cache_config.svh"

module tex_cache_mem (
	input  wire logic                         clk,
	input  wire logic                         reset,
	input  wire logic                         endian,

	output logic                              busy,

	input  wire tex_cache_pkg::user_t         s_user,
	input  wire logic                         s_last,
	input  wire logic [`TEX_COMPONENT_NUM-1:0] s_we,
	input  wire tex_cache_pkg::line_set_t     s_wdata,
	input  wire tex_cache_pkg::tag_addr_t     s_tag_addr,
	input  wire tex_cache_pkg::pix_addr_t     s_pix_addr,
	input  wire logic                         s_range_out,
	input  wire logic                         s_valid,
	output logic                              s_ready,

	output tex_cache_pkg::user_t              m_user,
	output logic                              m_last,
	output tex_cache_pkg::pixel_t             m_data,
	output logic                              m_valid,
	input  wire logic                         m_ready
);

	logic                       cke;
	logic [`TEX_COMPONENT_NUM-1:0] bank_we;
	tex_cache_pkg::word_addr_t  word_addr;
	tex_cache_pkg::line_set_t   bank_rdata;

	logic                       st1_valid;

	tex_cache_pkg::pix_sel_t    st2_sel;
	logic                       st2_valid;
	logic                       st2_last;
	logic                       st2_range_out;
	tex_cache_pkg::user_t       st2_user;

	tex_cache_pkg::pixel_t      st3_pixel;
	logic                       st3_valid;
	logic                       st3_last;
	tex_cache_pkg::user_t       st3_user;

	// whole pipeline stalls on the out buffer
	assign s_ready = cke;
	assign bank_we = s_we & {`TEX_COMPONENT_NUM{s_valid & cke}};
	assign busy    = !cke || s_valid || st1_valid || st2_valid || st3_valid || m_valid;

	// lookup sitting in stage 1
	always_ff @(posedge clk) begin
		if (reset) begin
			st1_valid <= 1'b0;
		end else if (cke) begin
			st1_valid <= s_valid;
		end
	end

	// ----------------------------------------
	// decode
	// ----------------------------------------
	tex_cache_req_decode req_decode_i (
		.clk           (clk),
		.reset         (reset),
		.cke           (cke),
		.valid         (s_valid),
		.last          (s_last),
		.range_out     (s_range_out),
		.user          (s_user),
		.pix_addr      (s_pix_addr),
		.tag_addr      (s_tag_addr),
		.word_addr     (word_addr),
		.st2_sel       (st2_sel),
		.st2_valid     (st2_valid),
		.st2_last      (st2_last),
		.st2_range_out (st2_range_out),
		.st2_user      (st2_user)
	);

	// ----------------------------------------
	// banks, one per component
	// ----------------------------------------
	for (genvar i = 0; i < `TEX_COMPONENT_NUM; i++) begin : gen_bank
		tex_cache_ram ram_i (
			.clk   (clk),
			.cke   (cke),
			.we    (bank_we[i]),
			.addr  (word_addr),
			.wdata (s_wdata[i]),
			.rdata (bank_rdata[i])
		);
	end

	// ----------------------------------------
	// select and output
	// ----------------------------------------
	tex_cache_pix_select pix_select_i (
		.clk       (clk),
		.reset     (reset),
		.cke       (cke),
		.endian    (endian),
		.sel       (st2_sel),
		.range_out (st2_range_out),
		.valid     (st2_valid),
		.last      (st2_last),
		.user      (st2_user),
		.lines     (bank_rdata),
		.pixel     (st3_pixel),
		.out_valid (st3_valid),
		.out_last  (st3_last),
		.out_user  (st3_user)
	);

	tex_cache_out_buffer out_buffer_i (
		.clk     (clk),
		.reset   (reset),
		.s_pixel (st3_pixel),
		.s_user  (st3_user),
		.s_last  (st3_last),
		.s_valid (st3_valid),
		.s_ready (cke),
		.m_pixel (m_data),
		.m_user  (m_user),
		.m_last  (m_last),
		.m_valid (m_valid),
		.m_ready (m_ready)
	);

endmodule

`default_nettype wire

/* tb_tex_cache_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "tex_cache_config.svh"

module tb_tex_cache_mem;

	// lookups per test, used for the run limit
	localparam int N_FILL   = 72;
	localparam int N_MASK   = 28;
	localparam int N_BORDER = 16;
	localparam int N_ENDIAN = 48;
	localparam int N_STREAM = 101;
	localparam int CYCLE_LIMIT = (N_FILL + N_MASK + N_BORDER + N_ENDIAN + N_STREAM) * 8 + 200;
	localparam int DEPTH = 1 << $bits(tex_cache_pkg::word_addr_t);
	localparam int CN = `TEX_COMPONENT_NUM;

	logic                      clk;
	logic                      reset;
	logic                      endian;
	logic                      busy;
	tex_cache_pkg::user_t      s_user;
	logic                      s_last;
	logic [CN-1:0]             s_we;
	tex_cache_pkg::line_set_t  s_wdata;
	tex_cache_pkg::tag_addr_t  s_tag_addr;
	tex_cache_pkg::pix_addr_t  s_pix_addr;
	logic                      s_range_out;
	logic                      s_valid;
	logic                      s_ready;
	tex_cache_pkg::user_t      m_user;
	logic                      m_last;
	tex_cache_pkg::pixel_t     m_data;
	logic                      m_valid;
	logic                      m_ready;

	// reference memory and expected results
	tex_cache_pkg::line_u      model [CN][DEPTH];
	bit                        known [DEPTH];
	tex_cache_pkg::pixel_t     exp_pixel_q [$];
	tex_cache_pkg::user_t      exp_user_q [$];
	logic                      exp_last_q [$];
	bit                        exp_chk_q [$];
	tex_cache_pkg::pixel_t     mon_pixel;
	tex_cache_pkg::user_t      mon_user;
	logic                      mon_last;
	bit                        mon_chk;
	tex_cache_pkg::tag_addr_t  tags [3] = '{4'h1, 4'h6, 4'hc};
	int                        cycles;
	bit                        toggle_ready;

	tex_cache_mem tex_cache_mem_i (
		.clk         (clk),
		.reset       (reset),
		.endian      (endian),
		.busy        (busy),
		.s_user      (s_user),
		.s_last      (s_last),
		.s_we        (s_we),
		.s_wdata     (s_wdata),
		.s_tag_addr  (s_tag_addr),
		.s_pix_addr  (s_pix_addr),
		.s_range_out (s_range_out),
		.s_valid     (s_valid),
		.s_ready     (s_ready),
		.m_user      (m_user),
		.m_last      (m_last),
		.m_data      (m_data),
		.m_valid     (m_valid),
		.m_ready     (m_ready)
	);

	always #5 clk = ~clk;

	// ----------------------------------------
	// checking
	// ----------------------------------------
	task automatic compare_pixel(input tex_cache_pkg::pixel_t got, exp);
		if (got !== exp) begin
			$display("** Error at %0t: m_data got %h expected %h", $time, got, exp);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	task automatic compare_side(input tex_cache_pkg::user_t got_user, exp_user,
			input logic got_last, exp_last);
		if (got_user !== exp_user) begin
			$display("** Error at %0t: m_user got %h expected %h", $time, got_user, exp_user);
			$display("tests failed");
			$fatal(1);
		end
		if (got_last !== exp_last) begin
			$display("** Error at %0t: m_last got %b expected %b", $time, got_last, exp_last);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!reset && !busy && exp_pixel_q.size() != 0) begin
			$display("busy was low while a lookup was outstanding at %0t", $time);
			$display("tests failed");
			$fatal(1);
		end
		if (!reset && m_valid && m_ready) begin
			if (exp_pixel_q.size() == 0) begin
				$display("output beat arrived with no lookup outstanding at %0t", $time);
				$display("tests failed");
				$fatal(1);
			end else begin
				mon_pixel = exp_pixel_q.pop_front();
				mon_user  = exp_user_q.pop_front();
				mon_last  = exp_last_q.pop_front();
				mon_chk   = exp_chk_q.pop_front();
				if (mon_chk) begin
					compare_pixel(m_data, mon_pixel);
				end
				compare_side(m_user, mon_user, m_last, mon_last);
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("tests failed");
			$fatal(1);
		end
	end

	// sink ready, random while streaming
	always @(posedge clk) begin
		#1;
		m_ready = toggle_ready ? 1'($urandom % 2) : 1'b1;
	end

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------
	function automatic tex_cache_pkg::line_set_t rand_lines();
		tex_cache_pkg::line_set_t l;
		for (int c = 0; c < CN; c++) begin
			l[c].word = $urandom;
		end
		return l;
	endfunction

	// drive one lookup and hold it until accepted, then update the model
	task automatic issue(input tex_cache_pkg::tag_addr_t tag, input tex_cache_pkg::pix_addr_t pix,
			input logic [CN-1:0] we, input logic range_out);
		tex_cache_pkg::line_set_t wd;
		tex_cache_pkg::word_addr_t wa;
		tex_cache_pkg::pixel_t exp;
		tex_cache_pkg::user_t usr;
		logic lst;
		logic rdy;
		int idx;
		wd  = rand_lines();
		usr = $urandom;
		lst = $urandom % 2;
		s_tag_addr  = tag;
		s_pix_addr  = pix;
		s_we        = we;
		s_wdata     = wd;
		s_range_out = range_out;
		s_user      = usr;
		s_last      = lst;
		s_valid     = 1'b1;
		do begin
			rdy = s_ready;
			@(posedge clk);
			#1;
		end while (!rdy);
		wa  = {tag, pix[`TEX_PIX_ADDR_WIDTH-1:`TEX_LINE_SIZE]};
		idx = pix[`TEX_LINE_SIZE-1:0];
		if (endian) begin
			idx = `TEX_LINE_PIX - 1 - idx;
		end
		for (int c = 0; c < CN; c++) begin
			exp[c] = model[c][wa].pix[idx];
		end
		if (range_out) begin
			exp = tex_cache_pkg::pixel_t'(`TEX_BORDER_DATA);
		end
		exp_pixel_q.push_back(exp);
		exp_user_q.push_back(usr);
		exp_last_q.push_back(lst);
		exp_chk_q.push_back(range_out || known[wa]);
		// read first, so the model changes after the expected value
		for (int c = 0; c < CN; c++) begin
			if (we[c]) begin
				model[c][wa] = wd[c];
			end
		end
		if (&we) begin
			known[wa] = 1'b1;
		end
	endtask

	task automatic idle();
		s_valid = 1'b0;
		s_we    = '0;
	endtask

	task automatic wait_drain();
		do begin
			@(negedge clk);
		end while (busy || exp_pixel_q.size() != 0);
		@(posedge clk);
		#1;
	endtask

	task automatic read_tag(input tex_cache_pkg::tag_addr_t tag);
		for (int p = 0; p < (1 << `TEX_PIX_ADDR_WIDTH); p++) begin
			issue(tag, p, '0, 1'b0);
		end
	endtask

	// ----------------------------------------
	// tests
	// ----------------------------------------
	task automatic test_fill_readback();
		// second pass checks the read-first data
		for (int pass = 0; pass < 2; pass++) begin
			for (int t = 0; t < 3; t++) begin
				for (int l = 0; l < `TEX_LINE_PIX; l++) begin
					issue(tags[t], (l << `TEX_LINE_SIZE), '1, 1'b0);
				end
			end
		end
		for (int t = 0; t < 3; t++) begin
			read_tag(tags[t]);
		end
		idle();
		wait_drain();
	endtask

	task automatic test_write_mask();
		for (int c = 0; c < CN; c++) begin
			for (int l = 0; l < `TEX_LINE_PIX; l++) begin
				issue(tags[0], (l << `TEX_LINE_SIZE) | ($urandom % 4), 1 << c, 1'b0);
			end
		end
		read_tag(tags[0]);
		idle();
		wait_drain();
	endtask

	task automatic test_border();
		for (int i = 0; i < N_BORDER; i++) begin
			if (i % 2 == 0) begin
				issue($urandom, $urandom, '0, 1'b1);
			end else begin
				issue(tags[i % 3], $urandom, '0, 1'b0);
			end
		end
		idle();
		wait_drain();
	endtask

	task automatic test_endian();
		endian = 1'b1;
		for (int t = 0; t < 3; t++) begin
			read_tag(tags[t]);
		end
		idle();
		wait_drain();
		endian = 1'b0;
	endtask

	task automatic test_stream();
		logic [CN-1:0] we;
		// lone lookup, m_valid rises on the fourth edge after it is driven
		issue(tags[1], 4'h5, '0, 1'b0);
		idle();
		repeat (3) begin
			@(negedge clk);
			if (m_valid) begin
				$display("m_valid rose before the fourth edge at %0t", $time);
				$display("tests failed");
				$fatal(1);
			end
		end
		@(negedge clk);
		if (!m_valid) begin
			$display("m_valid did not rise on the fourth edge at %0t", $time);
			$display("tests failed");
			$fatal(1);
		end
		wait_drain();
		toggle_ready = 1'b1;
		for (int i = 0; i < N_STREAM - 1; i++) begin
			we = ($urandom % 4 == 0) ? CN'($urandom) : '0;
			issue(tags[$urandom % 3], $urandom, we, 1'($urandom % 8 == 0));
		end
		idle();
		toggle_ready = 1'b0;
		wait_drain();
	endtask

	initial begin
		void'($urandom(32'hac3a));
		clk          = 1'b0;
		reset        = 1'b1;
		endian       = 1'b0;
		s_user       = '0;
		s_last       = 1'b0;
		s_we         = '0;
		s_wdata      = '0;
		s_tag_addr   = '0;
		s_pix_addr   = '0;
		s_range_out  = 1'b0;
		s_valid      = 1'b0;
		m_ready      = 1'b1;
		toggle_ready = 1'b0;
		cycles       = 0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		test_fill_readback();
		test_write_mask();
		test_border();
		test_endian();
		test_stream();

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tex_cache_mem.f */
+incdir+.
tex_cache_pkg.sv
tex_cache_req_decode.sv
tex_cache_ram.sv
tex_cache_pix_select.sv
tex_cache_out_buffer.sv
tex_cache_mem.sv
tb_tex_cache_mem.sv
